// File: src/hub75_pkg.sv
// HUB75 panel driver shared definitions
// panel geometry, modulation timing, pixel and pin bundles
package hub75_pkg;

    // bits per colour channel
    localparam int BRIGHTNESS_LEVELS = 4;
    // panel geometry, one half of the panel
    localparam int PIXEL_WIDTH = 16;
    localparam int PIXEL_HALFHEIGHT = 4;
    localparam int COLUMN_BITS = $clog2(PIXEL_WIDTH);
    localparam int ROW_BITS = $clog2(PIXEL_HALFHEIGHT);

    // on-time of the lsb plane, in cycles
    localparam int BRIGHTNESS_BASE_TIMEOUT = 8;
    // next shift may start at this remaining on-time
    // must stay below PIXEL_WIDTH so the latch never lands inside an on-time
    localparam int BRIGHTNESS_OVERLAP = 6;
    // wide enough for the msb plane on-time
    localparam int BRIGHTNESS_TIMER_BITS =
        $clog2(BRIGHTNESS_BASE_TIMEOUT << (BRIGHTNESS_LEVELS - 1)) + 1;

    typedef struct packed {
        logic [BRIGHTNESS_LEVELS-1:0] r;
        logic [BRIGHTNESS_LEVELS-1:0] g;
        logic [BRIGHTNESS_LEVELS-1:0] b;
    } pixel_t;

    // same column and row from both halves
    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    // host write address; half 0 is the upper half
    typedef struct packed {
        logic half;
        logic [ROW_BITS-1:0] row;
        logic [COLUMN_BITS-1:0] column;
    } pixel_addr_t;

    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
        logic clk_pixel;
        logic latch;
        logic oe_n;
        logic [ROW_BITS-1:0] row_addr;
    } hub75_pins_t;

endpackage

// File: src/scan_timeout.sv
// loadable down-counter
// runs for the loaded number of cycles after a start pulse
module scan_timeout #(
    parameter int COUNTER_WIDTH = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            // restart wins over a count in progress
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // high for exactly value cycles after the load
    assign running = (counter != '0);

endmodule

// File: src/frame_buffer.sv
// frame buffer for the upper and lower panel halves
// host write port, registered dual-bank read of one row/column
module frame_buffer
    import hub75_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   wr_en,
    input  pixel_addr_t            wr_addr,
    input  pixel_t                 wr_data,
    input  logic                   rd_en,
    input  logic [ROW_BITS-1:0]    rd_row,
    input  logic [COLUMN_BITS-1:0] rd_column,
    output pixel_pair_t            rd_data
);

    localparam int DEPTH = PIXEL_HALFHEIGHT * PIXEL_WIDTH;

    // one bank per panel half, indexed by {row, column}
    pixel_t bank_top [DEPTH];
    pixel_t bank_bottom [DEPTH];

    logic [ROW_BITS+COLUMN_BITS-1:0] wr_index;
    logic [ROW_BITS+COLUMN_BITS-1:0] rd_index;

    assign wr_index = {wr_addr.row, wr_addr.column};
    assign rd_index = {rd_row, rd_column};

    // half bit steers the write to one bank
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_addr.half) begin
                bank_bottom[wr_index] <= wr_data;
            end else begin
                bank_top[wr_index] <= wr_data;
            end
        end
    end

    // read sees the old word on a same-cycle write
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data.top <= bank_top[rd_index];
            rd_data.bottom <= bank_bottom[rd_index];
        end
    end

endmodule

// File: src/brightness_timer.sv
// output-enable timer for binary-coded modulation
// on-time is the base timeout weighted by the active plane bit
module brightness_timer
    import hub75_pkg::*;
(
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         row_latch,
    input  logic [BRIGHTNESS_LEVELS-1:0] mask_active,
    output logic                         output_enable,
    output logic                         overlap
);

    // remaining on-time in cycles
    logic [BRIGHTNESS_TIMER_BITS-1:0] remaining;
    logic [BRIGHTNESS_TIMER_BITS-1:0] load_value;

    // one-hot mask times base gives base << bit
    assign load_value = BRIGHTNESS_TIMER_BITS'(BRIGHTNESS_BASE_TIMEOUT * mask_active);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            remaining <= '0;
        end else if (row_latch) begin
            remaining <= load_value;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // leds lit while any on-time is left
    assign output_enable = (remaining != '0);

    // tail of the on-time, next plane may begin shifting
    assign overlap = output_enable &&
        (remaining <= BRIGHTNESS_TIMER_BITS'(BRIGHTNESS_OVERLAP));

    // scan must hand over exactly one plane bit per latch
    a_mask_onehot: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |-> $onehot(mask_active)
    );

endmodule

// File: src/matrix_scan.sv
// row and bit-plane sequencer
// issues column reads, the latch request and the plane masks, msb plane first
module matrix_scan
    import hub75_pkg::*;
(
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         output_enable,
    input  logic                         overlap,
    output logic                         rd_en,
    output logic [ROW_BITS-1:0]          rd_row,
    output logic [COLUMN_BITS-1:0]       rd_column,
    output logic                         latch_req,
    output logic [BRIGHTNESS_LEVELS-1:0] plane_mask,
    output logic                         row_latch,
    output logic [BRIGHTNESS_LEVELS-1:0] mask_active,
    output logic [ROW_BITS-1:0]          row_active
);

    localparam logic [BRIGHTNESS_LEVELS-1:0] MASK_MSB = 1 << (BRIGHTNESS_LEVELS - 1);

    logic       advance;
    logic [1:0] adv_state;
    logic       plane_start;
    logic       rd_en_q;

    // shift may begin once leds are dark or in the overlap tail
    assign advance = !output_enable || overlap;

    // history of advance, idle once it has been low two cycles
    always_ff @(posedge clk_in) begin
        if (reset) begin
            adv_state <= 2'b00;
        end else begin
            adv_state <= {adv_state[0], advance};
        end
    end

    assign plane_start = advance && (adv_state == 2'b00);

    // PIXEL_WIDTH read strobes per plane
    scan_timeout #(
        .COUNTER_WIDTH(COLUMN_BITS + 1)
    ) strobe_timer_i (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (plane_start),
        .value  ((COLUMN_BITS + 1)'(PIXEL_WIDTH)),
        .counter(),
        .running(rd_en)
    );

    // column address, counts down from the last column to 0
    scan_timeout #(
        .COUNTER_WIDTH(COLUMN_BITS)
    ) column_timer_i (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (plane_start),
        .value  (COLUMN_BITS'(PIXEL_WIDTH - 1)),
        .counter(rd_column),
        .running()
    );

    // falling edge of the strobe window
    assign latch_req = rd_en_q && !rd_en;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rd_en_q <= 1'b0;
            row_latch <= 1'b0;
            plane_mask <= MASK_MSB;
            rd_row <= '0;
            mask_active <= '0;
            row_active <= '0;
        end else begin
            rd_en_q <= rd_en;
            // one cycle later so mask_active is already updated
            row_latch <= latch_req;
            if (latch_req) begin
                mask_active <= plane_mask;
                row_active <= rd_row;
                if (plane_mask[0]) begin
                    // lsb done, next row from the msb plane
                    plane_mask <= MASK_MSB;
                    if (rd_row == ROW_BITS'(PIXEL_HALFHEIGHT - 1)) begin
                        rd_row <= '0;
                    end else begin
                        rd_row <= rd_row + 1'b1;
                    end
                end else begin
                    plane_mask <= plane_mask >> 1;
                end
            end
        end
    end

    // overlap tail has to end before the next latch
    a_latch_dark: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |-> !output_enable
    );

endmodule

// File: src/hub75_driver.sv
// HUB75 output stage
// aligns strobes with read data, picks plane bits, registers the panel pins
module hub75_driver
    import hub75_pkg::*;
(
    input  logic                         clk_in,
    input  logic                         reset,
    input  pixel_pair_t                  rd_data,
    input  logic                         shift_valid,
    input  logic [BRIGHTNESS_LEVELS-1:0] plane_mask,
    input  logic                         latch_req,
    input  logic [ROW_BITS-1:0]          row_active,
    input  logic                         output_enable,
    output hub75_pins_t                  panel
);

    // stage matching the frame buffer read latency
    logic                         shift_q;
    logic                         latch_q;
    logic [BRIGHTNESS_LEVELS-1:0] mask_q;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            shift_q <= 1'b0;
            latch_q <= 1'b0;
            mask_q <= '0;
        end else begin
            shift_q <= shift_valid;
            latch_q <= latch_req;
            mask_q <= plane_mask;
        end
    end

    // pin register; colours only driven while clocking pixels
    always_ff @(posedge clk_in) begin
        if (reset) begin
            panel <= '0;
            panel.oe_n <= 1'b1;
        end else begin
            panel.r0 <= shift_q && |(rd_data.top.r & mask_q);
            panel.g0 <= shift_q && |(rd_data.top.g & mask_q);
            panel.b0 <= shift_q && |(rd_data.top.b & mask_q);
            panel.r1 <= shift_q && |(rd_data.bottom.r & mask_q);
            panel.g1 <= shift_q && |(rd_data.bottom.g & mask_q);
            panel.b1 <= shift_q && |(rd_data.bottom.b & mask_q);
            panel.clk_pixel <= shift_q;
            panel.latch <= latch_q;
            // active row already lines up with the latch pin
            panel.row_addr <= row_active;
            panel.oe_n <= !output_enable;
        end
    end

endmodule

// File: src/hub75_top.sv
// HUB75 panel controller top
// frame buffer, scan sequencer, brightness timer and pin driver
module hub75_top
    import hub75_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic        wr_en,
    input  pixel_addr_t wr_addr,
    input  pixel_t      wr_data,
    output hub75_pins_t panel
);

    logic                         rd_en;
    logic [ROW_BITS-1:0]          rd_row;
    logic [COLUMN_BITS-1:0]       rd_column;
    pixel_pair_t                  rd_data;
    logic                         latch_req;
    logic [BRIGHTNESS_LEVELS-1:0] plane_mask;
    logic                         row_latch;
    logic [BRIGHTNESS_LEVELS-1:0] mask_active;
    logic [ROW_BITS-1:0]          row_active;
    logic                         output_enable;
    logic                         overlap;

    frame_buffer frame_buffer_i (
        .clk_in   (clk_in),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_row   (rd_row),
        .rd_column(rd_column),
        .rd_data  (rd_data)
    );

    matrix_scan matrix_scan_i (
        .clk_in       (clk_in),
        .reset        (reset),
        .output_enable(output_enable),
        .overlap      (overlap),
        .rd_en        (rd_en),
        .rd_row       (rd_row),
        .rd_column    (rd_column),
        .latch_req    (latch_req),
        .plane_mask   (plane_mask),
        .row_latch    (row_latch),
        .mask_active  (mask_active),
        .row_active   (row_active)
    );

    brightness_timer brightness_timer_i (
        .clk_in       (clk_in),
        .reset        (reset),
        .row_latch    (row_latch),
        .mask_active  (mask_active),
        .output_enable(output_enable),
        .overlap      (overlap)
    );

    // read strobe doubles as the shift valid
    hub75_driver hub75_driver_i (
        .clk_in       (clk_in),
        .reset        (reset),
        .rd_data      (rd_data),
        .shift_valid  (rd_en),
        .plane_mask   (plane_mask),
        .latch_req    (latch_req),
        .row_active   (row_active),
        .output_enable(output_enable),
        .panel        (panel)
    );

endmodule

// File: verif/hub75_tb.sv
// HUB75 controller testbench
// panel model rebuilds every shifted plane and checks it against a reference frame
module hub75_tb
    import hub75_pkg::*;
();

    localparam int PLANES_PER_FRAME = PIXEL_HALFHEIGHT * BRIGHTNESS_LEVELS;
    // generous bound on cycles between two latches
    localparam int CYCLES_PER_LATCH = 200;

    // one table row holds a pixel write or a wait in frames
    typedef struct packed {
        logic        is_wait;
        logic [3:0]  frames;
        pixel_addr_t addr;
        pixel_t      pixel;
    } stim_t;

    logic        clk_in = 1'b0;
    logic        reset;
    logic        wr_en;
    pixel_addr_t wr_addr;
    pixel_t      wr_data;
    hub75_pins_t panel;

    stim_t  stim_table[$];
    pixel_t ref_frame [2][PIXEL_HALFHEIGHT][PIXEL_WIDTH];
    // panel model channels in the order r0 g0 b0 r1 g1 b1
    logic [5:0]             colour_bits;
    logic [PIXEL_WIDTH-1:0] shift_reg [6];
    logic [PIXEL_WIDTH-1:0] shown [PIXEL_HALFHEIGHT][6];

    integer seed;
    int     mismatches = 0;
    int     other_errors = 0;
    int     latch_count = 0;
    int     pixel_count = 0;
    int     oe_low_count = 0;
    int     planes_compared = 0;
    int     last_write_latch = 0;
    int     exp_row = 0;
    int     exp_bit = BRIGHTNESS_LEVELS - 1;
    int     prev_bit = 0;
    logic   ref_ready = 1'b0;
    logic   timed_out = 1'b0;

    hub75_top dut_i (
        .clk_in (clk_in),
        .reset  (reset),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .panel  (panel)
    );

    always #10 clk_in = ~clk_in;

    // bit of one colour channel where ch modulo 3 picks r g b
    function automatic logic channel_bit(pixel_t p, int ch, int plane_bit);
        case (ch % 3)
            0: return p.r[plane_bit];
            1: return p.g[plane_bit];
            default: return p.b[plane_bit];
        endcase
    endfunction

    task automatic add_wait(int frames);
        stim_t e;
        e = '0;
        e.is_wait = 1'b1;
        e.frames = frames[3:0];
        stim_table.push_back(e);
    endtask

    // random pixels at random addresses written while the scan runs
    task automatic add_rewrites(int count);
        stim_t e;
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            e = '0;
            rnd = $random(seed);
            e.addr = rnd[$bits(pixel_addr_t)-1:0];
            rnd = $random(seed);
            e.pixel = rnd[$bits(pixel_t)-1:0];
            stim_table.push_back(e);
        end
    endtask

    task automatic build_table();
        stim_t e;
        logic [31:0] rnd;
        // whole frame of both halves first
        for (int i = 0; i < 2 * PIXEL_HALFHEIGHT * PIXEL_WIDTH; i++) begin
            e = '0;
            rnd = $random(seed);
            e.addr = i[$bits(pixel_addr_t)-1:0];
            e.pixel = rnd[$bits(pixel_t)-1:0];
            stim_table.push_back(e);
        end
        add_wait(2);
        add_rewrites(12);
        add_wait(1);
        add_rewrites(6);
        add_wait(1);
    endtask

    // runs at the latch pin and closes the plane that was just shifted
    task automatic check_latched_plane();
        logic exp_val;
        if (pixel_count != PIXEL_WIDTH) begin
            $display("MISMATCH %0t: %0d pixel clocks before latch, expected %0d",
                $time, pixel_count, PIXEL_WIDTH);
            mismatches++;
        end
        if (panel.oe_n !== 1'b1) begin
            $display("MISMATCH %0t: oe_n low at latch", $time);
            mismatches++;
        end
        // on-time of the previous plane is the base weighted by its bit
        if (latch_count > 0 && oe_low_count != (BRIGHTNESS_BASE_TIMEOUT << prev_bit)) begin
            $display("MISMATCH %0t: oe_n low %0d cycles for plane %0d, expected %0d",
                $time, oe_low_count, prev_bit, BRIGHTNESS_BASE_TIMEOUT << prev_bit);
            mismatches++;
        end
        if (panel.row_addr !== exp_row[ROW_BITS-1:0]) begin
            $display("MISMATCH %0t: row_addr %0d, expected %0d", $time, panel.row_addr, exp_row);
            mismatches++;
        end
        for (int ch = 0; ch < 6; ch++) begin
            shown[panel.row_addr][ch] = shift_reg[ch];
        end
        latch_count++;
        // only planes shifted wholly after the last host write
        if (ref_ready && latch_count >= last_write_latch + 2) begin
            planes_compared++;
            for (int ch = 0; ch < 6; ch++) begin
                for (int col = 0; col < PIXEL_WIDTH; col++) begin
                    exp_val = channel_bit(ref_frame[ch / 3][exp_row][col], ch, exp_bit);
                    if (shown[exp_row][ch][col] !== exp_val) begin
                        $display("MISMATCH %0t: row %0d plane %0d ch %0d col %0d got %b exp %b",
                            $time, exp_row, exp_bit, ch, col, shown[exp_row][ch][col], exp_val);
                        mismatches++;
                    end
                end
            end
        end
        pixel_count = 0;
        oe_low_count = 0;
        prev_bit = exp_bit;
        // msb to lsb and then the next row with wrap
        if (exp_bit == 0) begin
            exp_bit = BRIGHTNESS_LEVELS - 1;
            exp_row = (exp_row + 1) % PIXEL_HALFHEIGHT;
        end else begin
            exp_bit--;
        end
    endtask

    // panel model sampled mid-cycle
    always @(negedge clk_in) begin
        colour_bits = {panel.r0, panel.g0, panel.b0, panel.r1, panel.g1, panel.b1};
        if (reset) begin
            if (colour_bits !== 6'b0 || panel.clk_pixel !== 1'b0 || panel.latch !== 1'b0 ||
                panel.oe_n !== 1'b1 || panel.row_addr !== '0) begin
                $display("MISMATCH %0t: panel pins not idle in reset", $time);
                mismatches++;
            end
        end else begin
            if (panel.clk_pixel) begin
                for (int ch = 0; ch < 6; ch++) begin
                    shift_reg[ch] = {shift_reg[ch][PIXEL_WIDTH-2:0], colour_bits[5 - ch]};
                end
                pixel_count++;
            end
            if (panel.oe_n == 1'b0) begin
                oe_low_count++;
            end
            if (latch_count == 0 && panel.oe_n !== 1'b1) begin
                $display("MISMATCH %0t: oe_n low before the first latch", $time);
                mismatches++;
            end
            if (panel.latch) begin
                check_latched_plane();
            end
        end
    end

    // waits for whole frames of latches
    task automatic wait_frames(int frames);
        int target;
        int cycles;
        target = latch_count + frames * PLANES_PER_FRAME + 2;
        cycles = 0;
        while (latch_count < target &&
               cycles < (frames * PLANES_PER_FRAME + 2) * CYCLES_PER_LATCH) begin
            @(posedge clk_in);
            cycles++;
        end
        if (latch_count < target) begin
            $display("ERROR %0t: timeout, the panel stopped latching rows", $time);
            other_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_entry(stim_t e);
        @(posedge clk_in);
        if (e.is_wait) begin
            wr_en <= 1'b0;
            wait_frames(int'(e.frames));
        end else begin
            wr_en <= 1'b1;
            wr_addr <= e.addr;
            wr_data <= e.pixel;
            ref_frame[e.addr.half][e.addr.row][e.addr.column] = e.pixel;
            last_write_latch = latch_count;
            ref_ready = 1'b1;
        end
    endtask

    initial begin
        seed = 32'h1b27_560e;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        build_table();
        repeat (16) @(posedge clk_in);
        reset <= 1'b0;
        for (int i = 0; i < stim_table.size() && !timed_out; i++) begin
            apply_entry(stim_table[i]);
        end
        @(posedge clk_in);
        wr_en <= 1'b0;
        if (planes_compared == 0) begin
            $display("ERROR: no plane was latched and compared");
            other_errors++;
        end
        $display("mismatches: %0d, other errors: %0d, latches: %0d, planes compared: %0d",
            mismatches, other_errors, latch_count, planes_compared);
        if (mismatches == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sources.f
src/hub75_pkg.sv
src/scan_timeout.sv
src/frame_buffer.sv
src/brightness_timer.sv
src/matrix_scan.sv
src/hub75_driver.sv
src/hub75_top.sv
verif/hub75_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --sv --timing
SIM_FLAGS   = --binary --sv --timing --assert
TOP         = hub75_tb
RTL_TOP     = hub75_top
FILELIST    = sources.f
OBJ_DIR     = obj_dir
PASS_MSG    = *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
